//--- filelist.f
common/mips_pkg.sv
hw/execute/alu.sv
hw/execute/register_file.sv
hw/execute/decode_unit.sv
hw/execute/exec_stage.sv
hw/fetch_buffer.sv
hw/fetch/instr_fetch.sv
hw/mips_top.sv
tests/mips_props.sv
tests/mips_tb.sv

//--- Bender.yml
package:
  name: mips_core

sources:
  - common/mips_pkg.sv
  - hw/execute/alu.sv
  - hw/execute/register_file.sv
  - hw/execute/decode_unit.sv
  - hw/execute/exec_stage.sv
  - hw/fetch_buffer.sv
  - hw/fetch/instr_fetch.sv
  - hw/mips_top.sv
  - target: test
    files:
      - tests/mips_props.sv
      - tests/mips_tb.sv

//--- tests/mips_tb.sv
`timescale 1ns/10ps
`default_nettype none

module mips_tb;
    import mips_pkg::*;

    // Three programs of about 16 words at half step rate, with margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic        i_clk;
    logic        i_arst_n;
    logic        i_step;
    imem_write_t i_imem_wr;
    reg_addr_t   i_dbg_reg_addr;
    word_t       o_dbg_reg_data;
    word_t       o_pc;
    logic        o_halted;

    word_t prog [$];
    word_t exp_regs [NUM_REGS];
    int    reg_errors = 0;
    int    cycle_count = 0;

    mips_top uut (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_step         (i_step),
        .i_imem_wr      (i_imem_wr),
        .i_dbg_reg_addr (i_dbg_reg_addr),
        .o_dbg_reg_data (o_dbg_reg_data),
        .o_pc           (o_pc),
        .o_halted       (o_halted)
    );

    bind mips_top mips_props u_props (
        .i_clk         (i_clk),
        .i_arst_n      (i_arst_n),
        .i_fetch_valid (if_valid),
        .i_fetch_ready (if_ready),
        .i_pc          (o_pc),
        .i_halted      (o_halted)
    );

    always #2 i_clk = ~i_clk;

    function automatic word_t r_type_word(funct_e fn, int rs, int rt, int rd, int sh);
        return {OP_RTYPE, 5'(rs), 5'(rt), 5'(rd), 5'(sh), fn};
    endfunction

    function automatic word_t i_type_word(opcode_e op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    // ISA reference model up to the halt word
    function automatic void model_program();
        word_t     instr;
        word_t     a;
        word_t     b;
        word_t     res;
        reg_addr_t dst;
        logic      wr;
        exp_regs = '{default: '0};
        for (int i = 0; i < prog.size(); i++) begin
            instr = prog[i];
            if (instr[31:26] == OP_HALT) break;
            a   = exp_regs[instr[25:21]];
            b   = exp_regs[instr[20:16]];
            dst = instr[20:16];
            res = '0;
            wr  = 1'b1;
            case (instr[31:26])
                OP_RTYPE: begin
                    dst = instr[15:11];
                    case (instr[5:0])
                        FN_ADD:  res = a + b;
                        FN_SUB:  res = a - b;
                        FN_AND:  res = a & b;
                        FN_OR:   res = a | b;
                        FN_XOR:  res = a ^ b;
                        FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        FN_SLL:  res = b << instr[10:6];
                        FN_SRL:  res = b >> instr[10:6];
                        default: wr = 1'b0;
                    endcase
                end
                OP_ADDI: res = a + {{16{instr[15]}}, instr[15:0]};
                OP_ANDI: res = a & {16'h0000, instr[15:0]};
                OP_ORI:  res = a | {16'h0000, instr[15:0]};
                OP_LUI:  res = {instr[15:0], 16'h0000};
                default: wr = 1'b0;
            endcase
            if (wr && dst != '0) exp_regs[dst] = res;
        end
    endfunction

    // Program goes in through the debug port while reset is held
    task automatic reset_and_load();
        @(negedge i_clk);
        i_arst_n = 1'b0;
        i_step   = 1'b0;
        for (int i = 0; i < 16; i++) begin
            i_imem_wr.en   = (i < prog.size());
            i_imem_wr.addr = imem_addr_t'(i);
            i_imem_wr.data = (i < prog.size()) ? prog[i] : '0;
            @(negedge i_clk);
        end
        i_imem_wr = '0;
        i_arst_n  = 1'b1;
    endtask

    task automatic check_registers();
        for (int r = 0; r < NUM_REGS; r++) begin
            @(negedge i_clk);
            i_dbg_reg_addr = reg_addr_t'(r);
            @(posedge i_clk);
            assert (o_dbg_reg_data == exp_regs[r]) else begin
                $display("ERROR: o_dbg_reg_data r%0d is %h, expected %h",
                         r, o_dbg_reg_data, exp_regs[r]);
                reg_errors++;
            end
        end
    endtask

    task automatic run_program(input logic random_step);
        reset_and_load();
        while (!o_halted) begin
            i_step = random_step ? 1'($urandom) : 1'b1;
            @(negedge i_clk);
        end
        // Anything past the halt word would retire here
        i_step = 1'b1;
        repeat (8) @(negedge i_clk);
        model_program();
        check_registers();
    endtask

    task automatic print_counts();
        $display("Register mismatches: %0d, assertion failures: %0d",
                 reg_errors, uut.u_props.fail_count);
    endtask

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            print_counts();
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        i_clk          = 1'b0;
        i_arst_n       = 1'b0;
        i_step         = 1'b0;
        i_imem_wr      = '0;
        i_dbg_reg_addr = '0;
        void'($urandom(32'h30918e0d));

        // Every kept operation, dependent pairs, and a write to r0
        prog = '{
            i_type_word(OP_ADDI, 0, 1, 16'h1234),
            i_type_word(OP_ADDI, 1, 2, 16'hfffb),
            i_type_word(OP_LUI, 0, 3, 16'h8000),
            i_type_word(OP_ORI, 3, 3, 16'h80ff),
            i_type_word(OP_ANDI, 3, 4, 16'h8f0f),
            r_type_word(FN_ADD, 1, 2, 5, 0),
            r_type_word(FN_SUB, 4, 5, 6, 0),
            r_type_word(FN_AND, 3, 2, 7, 0),
            r_type_word(FN_OR, 6, 1, 8, 0),
            r_type_word(FN_XOR, 8, 3, 9, 0),
            r_type_word(FN_SLT, 3, 6, 10, 0),
            r_type_word(FN_SLT, 1, 3, 11, 0),
            r_type_word(FN_SLL, 0, 9, 12, 7),
            r_type_word(FN_SRL, 0, 3, 13, 4),
            i_type_word(OP_ADDI, 1, 0, 16'h0001),
            {OP_HALT, 26'h0}
        };
        run_program(1'b0);
        // Same program under random back-pressure
        run_program(1'b1);

        prog = '{
            i_type_word(OP_ADDI, 0, 1, 16'h0007),
            r_type_word(FN_ADD, 1, 1, 2, 0),
            {OP_HALT, 26'h0},
            i_type_word(OP_ADDI, 0, 3, 16'h0055),
            i_type_word(OP_LUI, 0, 1, 16'hffff),
            r_type_word(FN_SUB, 0, 1, 2, 0)
        };
        run_program(1'b0);

        print_counts();
        if (reg_errors == 0 && uut.u_props.fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tests/mips_props.sv
`timescale 1ns/10ps
`default_nettype none

module mips_props (
    input wire              i_clk,
    input wire              i_arst_n,
    input wire              i_fetch_valid,
    input wire              i_fetch_ready,
    input mips_pkg::word_t  i_pc,
    input wire              i_halted
);
    import mips_pkg::*;

    int fail_count = 0;

    // Nothing fetched yet, so state is still at reset values
    reset_state: assert property (@(posedge i_clk)
        !i_fetch_valid |-> (i_pc == '0) && !i_halted)
        else begin
            $error("PC or halt flag not cleared before the first fetch");
            fail_count++;
        end

    // Buffer full and execute not ready
    stall_hold: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        (i_fetch_valid && !i_fetch_ready) |=> $stable(i_pc))
        else begin
            $error("PC moved while fetch was stalled");
            fail_count++;
        end

    halt_sticky: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_halted |=> i_halted)
        else begin
            $error("Halt flag dropped without a reset");
            fail_count++;
        end

    halt_freeze: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        i_halted [*3] |=> $stable(i_pc))
        else begin
            $error("PC moved after the core halted");
            fail_count++;
        end

    // Wraps at the byte size of the instruction memory
    pc_step: assert property (@(posedge i_clk) disable iff (!i_arst_n)
        $changed(i_pc) |->
            i_pc == word_t'(($past(i_pc) + 32'd4) & word_t'(IMEM_DEPTH * 4 - 1)))
        else begin
            $error("PC changed by something other than one word");
            fail_count++;
        end

endmodule

`default_nettype wire

//--- hw/mips_top.sv
`timescale 1ns/10ps
`default_nettype none

module mips_top (
    input  wire                    i_clk,
    input  wire                    i_arst_n,
    input  wire                    i_step,
    input  mips_pkg::imem_write_t  i_imem_wr,
    input  mips_pkg::reg_addr_t    i_dbg_reg_addr,
    output mips_pkg::word_t        o_dbg_reg_data,
    output mips_pkg::word_t        o_pc,
    output logic                   o_halted
);
    import mips_pkg::*;

    // Fetch to buffer
    logic        if_valid;
    logic        if_ready;
    fetch_item_t if_item;

    // Buffer to execute
    logic        ex_valid;
    logic        ex_ready;
    fetch_item_t ex_item;

    instr_fetch u_fetch (
        .i_clk     (i_clk),
        .i_arst_n  (i_arst_n),
        .i_imem_wr (i_imem_wr),
        .o_valid   (if_valid),
        .i_ready   (if_ready),
        .o_item    (if_item),
        .o_pc      (o_pc)
    );

    fetch_buffer u_buffer (
        .i_clk    (i_clk),
        .i_arst_n (i_arst_n),
        .i_valid  (if_valid),
        .o_ready  (if_ready),
        .i_item   (if_item),
        .o_valid  (ex_valid),
        .i_ready  (ex_ready),
        .o_item   (ex_item)
    );

    exec_stage u_exec (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_step         (i_step),
        .i_valid        (ex_valid),
        .o_ready        (ex_ready),
        .i_item         (ex_item),
        .i_dbg_reg_addr (i_dbg_reg_addr),
        .o_dbg_reg_data (o_dbg_reg_data),
        .o_halted       (o_halted)
    );

endmodule

`default_nettype wire

//--- hw/fetch/instr_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module instr_fetch (
    input  wire                    i_clk,
    input  wire                    i_arst_n,
    input  mips_pkg::imem_write_t  i_imem_wr,
    output logic                   o_valid,
    input  wire                    i_ready,
    output mips_pkg::fetch_item_t  o_item,
    output mips_pkg::word_t        o_pc
);
    import mips_pkg::*;

    word_t      mem [IMEM_DEPTH];
    word_t      pc_q;
    word_t      pc_next;
    imem_addr_t word_idx;
    logic       active_q;

    // Debug port loads the program, also while in reset
    always_ff @(posedge i_clk) begin
        if (i_imem_wr.en) begin
            mem[i_imem_wr.addr] <= i_imem_wr.data;
        end
    end

    assign word_idx = pc_q[IMEM_ADDR_W+1:2];

    // Index wraps at the end of memory
    assign pc_next = word_t'({word_idx + 1'b1, 2'b00});

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            pc_q     <= '0;
            active_q <= 1'b0;
        end else begin
            active_q <= 1'b1;
            if (active_q && i_ready) begin
                pc_q <= pc_next;
            end
        end
    end

    assign o_valid      = active_q;
    assign o_item.pc    = pc_q;
    assign o_item.instr = mem[word_idx];
    assign o_pc         = pc_q;

endmodule

`default_nettype wire

//--- hw/fetch_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_buffer (
    input  wire                    i_clk,
    input  wire                    i_arst_n,
    input  wire                    i_valid,
    output logic                   o_ready,
    input  mips_pkg::fetch_item_t  i_item,
    output logic                   o_valid,
    input  wire                    i_ready,
    output mips_pkg::fetch_item_t  o_item
);
    import mips_pkg::*;

    fetch_item_t slot_q [2];
    logic        wr_ptr_q;
    logic        rd_ptr_q;
    logic [1:0]  count_q;
    logic        push;
    logic        pop;

    assign o_valid = (count_q != 2'd0);
    // When full, a slot frees up on the same edge as a pop
    assign o_ready = (count_q != 2'd2) || i_ready;

    assign push = i_valid && o_ready;
    assign pop  = o_valid && i_ready;

    always_ff @(posedge i_clk) begin
        if (push) begin
            slot_q[wr_ptr_q] <= i_item;
        end
    end

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 2'd1;
                2'b01:   count_q <= count_q - 2'd1;
                default: count_q <= count_q;
            endcase
        end
    end

    assign o_item = slot_q[rd_ptr_q];

endmodule

`default_nettype wire

//--- hw/execute/exec_stage.sv
`timescale 1ns/10ps
`default_nettype none

module exec_stage (
    input  wire                    i_clk,
    input  wire                    i_arst_n,
    input  wire                    i_step,
    input  wire                    i_valid,
    output logic                   o_ready,
    input  mips_pkg::fetch_item_t  i_item,
    input  mips_pkg::reg_addr_t    i_dbg_reg_addr,
    output mips_pkg::word_t        o_dbg_reg_data,
    output logic                   o_halted
);
    import mips_pkg::*;

    ctrl_t      ctrl;
    word_t      rs_data;
    word_t      rt_data;
    word_t      imm_ext;
    word_t      op_b;
    word_t      result;
    logic [4:0] shamt;
    logic       fire;
    logic       halted_q;

    assign o_ready = i_step && !halted_q;
    assign fire    = i_valid && o_ready;

    decode_unit u_decode (
        .i_instr (i_item.instr),
        .o_ctrl  (ctrl)
    );

    register_file u_regs (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_rs_addr  (i_item.instr[25:21]),
        .i_rt_addr  (i_item.instr[20:16]),
        .o_rs_data  (rs_data),
        .o_rt_data  (rt_data),
        .i_we       (fire && ctrl.reg_write),
        .i_wr_addr  (ctrl.dst),
        .i_wr_data  (result),
        .i_dbg_addr (i_dbg_reg_addr),
        .o_dbg_data (o_dbg_reg_data)
    );

    assign imm_ext = ctrl.zero_ext ? {16'h0000, i_item.instr[15:0]}
                                   : {{16{i_item.instr[15]}}, i_item.instr[15:0]};
    assign op_b    = ctrl.use_imm ? imm_ext : rt_data;
    // Fixed shamt field, else low bits of rs
    assign shamt   = ctrl.use_shamt ? i_item.instr[10:6] : rs_data[4:0];

    alu u_alu (
        .i_op     (ctrl.alu_op),
        .i_a      (rs_data),
        .i_b      (op_b),
        .i_shamt  (shamt),
        .o_result (result)
    );

    // Sticky until reset
    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            halted_q <= 1'b0;
        end else if (fire && ctrl.halt) begin
            halted_q <= 1'b1;
        end
    end

    assign o_halted = halted_q;

endmodule

`default_nettype wire

//--- hw/execute/decode_unit.sv
`timescale 1ns/10ps
`default_nettype none

module decode_unit (
    input  mips_pkg::word_t  i_instr,
    output mips_pkg::ctrl_t  o_ctrl
);
    import mips_pkg::*;

    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rt;
    reg_addr_t rd;

    assign opcode = opcode_e'(i_instr[31:26]);
    assign funct  = funct_e'(i_instr[5:0]);
    assign rt     = i_instr[20:16];
    assign rd     = i_instr[15:11];

    always_comb begin
        o_ctrl.alu_op    = ALU_ADD;
        o_ctrl.use_imm   = 1'b0;
        o_ctrl.zero_ext  = 1'b0;
        o_ctrl.use_shamt = 1'b0;
        o_ctrl.reg_write = 1'b0;
        o_ctrl.dst       = rt;
        o_ctrl.halt      = 1'b0;

        case (opcode)
            OP_RTYPE: begin
                o_ctrl.dst       = rd;
                o_ctrl.reg_write = 1'b1;
                case (funct)
                    FN_ADD: o_ctrl.alu_op = ALU_ADD;
                    FN_SUB: o_ctrl.alu_op = ALU_SUB;
                    FN_AND: o_ctrl.alu_op = ALU_AND;
                    FN_OR:  o_ctrl.alu_op = ALU_OR;
                    FN_XOR: o_ctrl.alu_op = ALU_XOR;
                    FN_SLT: o_ctrl.alu_op = ALU_SLT;
                    FN_SLL: begin
                        o_ctrl.alu_op    = ALU_SLL;
                        o_ctrl.use_shamt = 1'b1;
                    end
                    FN_SRL: begin
                        o_ctrl.alu_op    = ALU_SRL;
                        o_ctrl.use_shamt = 1'b1;
                    end
                    // Unknown funct retires as a no-op
                    default: o_ctrl.reg_write = 1'b0;
                endcase
            end
            OP_ADDI: begin
                o_ctrl.use_imm   = 1'b1;
                o_ctrl.reg_write = 1'b1;
            end
            OP_ANDI: begin
                o_ctrl.alu_op    = ALU_AND;
                o_ctrl.use_imm   = 1'b1;
                o_ctrl.zero_ext  = 1'b1;
                o_ctrl.reg_write = 1'b1;
            end
            OP_ORI: begin
                o_ctrl.alu_op    = ALU_OR;
                o_ctrl.use_imm   = 1'b1;
                o_ctrl.zero_ext  = 1'b1;
                o_ctrl.reg_write = 1'b1;
            end
            OP_LUI: begin
                o_ctrl.alu_op    = ALU_LUI;
                o_ctrl.use_imm   = 1'b1;
                o_ctrl.zero_ext  = 1'b1;
                o_ctrl.reg_write = 1'b1;
            end
            OP_HALT: o_ctrl.halt = 1'b1;
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/execute/register_file.sv
`timescale 1ns/10ps
`default_nettype none

module register_file (
    input  wire                  i_clk,
    input  wire                  i_arst_n,
    input  mips_pkg::reg_addr_t  i_rs_addr,
    input  mips_pkg::reg_addr_t  i_rt_addr,
    output mips_pkg::word_t      o_rs_data,
    output mips_pkg::word_t      o_rt_data,
    input  wire                  i_we,
    input  mips_pkg::reg_addr_t  i_wr_addr,
    input  mips_pkg::word_t      i_wr_data,
    input  mips_pkg::reg_addr_t  i_dbg_addr,
    output mips_pkg::word_t      o_dbg_data
);
    import mips_pkg::*;

    word_t regs_q [NUM_REGS];

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (i_we && (i_wr_addr != '0)) begin
            // r0 never takes a write
            regs_q[i_wr_addr] <= i_wr_data;
        end
    end

    assign o_rs_data  = regs_q[i_rs_addr];
    assign o_rt_data  = regs_q[i_rt_addr];
    assign o_dbg_data = regs_q[i_dbg_addr];

endmodule

`default_nettype wire

//--- hw/execute/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  mips_pkg::alu_op_e  i_op,
    input  mips_pkg::word_t    i_a,
    input  mips_pkg::word_t    i_b,
    input  wire [4:0]          i_shamt,
    output mips_pkg::word_t    o_result
);
    import mips_pkg::*;

    always_comb begin
        case (i_op)
            ALU_ADD: o_result = i_a + i_b;
            ALU_SUB: o_result = i_a - i_b;
            ALU_AND: o_result = i_a & i_b;
            ALU_OR:  o_result = i_a | i_b;
            ALU_XOR: o_result = i_a ^ i_b;
            ALU_SLT: o_result = word_t'($signed(i_a) < $signed(i_b));
            // Shifts act on B, like MIPS rt
            ALU_SLL: o_result = i_b << i_shamt;
            ALU_SRL: o_result = i_b >> i_shamt;
            ALU_LUI: o_result = {i_b[15:0], 16'h0000};
            default: o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- common/mips_pkg.sv
`default_nettype none

package mips_pkg;

    localparam int DATA_W      = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int NUM_REGS    = 32;
    localparam int IMEM_DEPTH  = 256;
    localparam int IMEM_ADDR_W = 8;

    typedef logic [DATA_W-1:0]      word_t;
    typedef logic [REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [IMEM_ADDR_W-1:0] imem_addr_t;

    // Primary opcode field, bits 31:26
    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_ADDI  = 6'h08,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_LUI   = 6'h0f,
        OP_HALT  = 6'h3f
    } opcode_e;

    // R-type function field, bits 5:0
    typedef enum logic [5:0] {
        FN_SLL = 6'h00,
        FN_SRL = 6'h02,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_XOR = 6'h26,
        FN_SLT = 6'h2a
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLL,
        ALU_SRL,
        ALU_LUI
    } alu_op_e;

    // Debug write into instruction memory
    typedef struct packed {
        logic       en;
        imem_addr_t addr;
        word_t      data;
    } imem_write_t;

    // Fetched instruction with its byte address
    typedef struct packed {
        word_t pc;
        word_t instr;
    } fetch_item_t;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      use_imm;
        logic      zero_ext;
        logic      use_shamt;
        logic      reg_write;
        reg_addr_t dst;
        logic      halt;
    } ctrl_t;

endpackage

`default_nettype wire
